/* files.f */
synth_pkg.sv
slot_counter.sv
frame_sequencer.sv
note_sync.sv
phase_accum.sv
env_gen.sv
voice_mixer.sv
synth_engine.sv
synth_checker.sv
synth_tb.sv

/* Bender.yml */
package:
  name: synth_engine

sources:
  - files:
      - synth_pkg.sv
      - slot_counter.sv
      - frame_sequencer.sv
      - note_sync.sv
      - phase_accum.sv
      - env_gen.sv
      - voice_mixer.sv
      - synth_engine.sv
  - target: test
    files:
      - synth_checker.sv
      - synth_tb.sv

/* synth_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module synth_tb;

    localparam int clk_period     = 20;
    localparam int drive_delay    = 2;
    localparam int reset_cycles   = 10;
    localparam int num_frames     = 60;
    localparam int frame_budget   = 40;  // writes, notes, frame and stalls
    localparam int timeout_cycles = num_frames * frame_budget + reset_cycles + 100;
    localparam int nv             = synth_pkg::num_voices;

    logic        reg_clk, reset, trig, note_valid, note_on, reg_write, reg_sel, sample_ready;
    logic [2:0]  note_voice, reg_voice;
    logic [15:0] reg_data;
    wire         note_ready, sample_valid;
    wire signed [synth_pkg::sample_width-1:0] sample;
    wire [nv-1:0] voice_free;

    logic [15:0] ref_phase [nv];
    logic [15:0] ref_inc [nv];
    logic [7:0]  ref_attack [nv];
    logic [7:0]  ref_release [nv];
    logic [7:0]  ref_level [nv];
    logic        ref_key [nv];
    logic [31:0] rand_state = 32'hd554;
    int          tb_errors = 0;
    int          cycles = 0;
    bit          stall_mode = 0;
    bit          trig_in_hold = 0;

    synth_engine i_dut (
        .reg_clk(reg_clk), .reset(reset), .trig(trig),
        .note_valid(note_valid), .note_voice(note_voice), .note_on(note_on),
        .reg_write(reg_write), .reg_voice(reg_voice), .reg_sel(reg_sel),
        .reg_data(reg_data), .sample_ready(sample_ready), .note_ready(note_ready),
        .sample_valid(sample_valid), .sample(sample), .voice_free(voice_free)
    );

    synth_checker i_checker (
        .reg_clk(reg_clk), .reset(reset), .trig(trig), .note_ready(note_ready),
        .sample_valid(sample_valid), .sample_ready(sample_ready), .sample(sample)
    );

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // one frame of the voice rules, returns the mixed sample
    function automatic logic signed [15:0] expected_frame_sample();
        int sum, lvl, wave, prod;
        sum = 0;
        for (int v = 0; v < nv; v++) begin
            ref_phase[v] = ref_phase[v] + ref_inc[v];  // wraps at 16 bits
            lvl = ref_level[v];
            if (ref_key[v]) begin
                lvl = (lvl + ref_attack[v] > 255) ? 255 : lvl + ref_attack[v];
            end else begin
                lvl = (lvl < ref_release[v]) ? 0 : lvl - ref_release[v];
            end
            ref_level[v] = lvl;
            wave = int'(ref_phase[v][15:8]) - 128;  // msb flipped top byte
            prod = wave * lvl;
            prod = (prod < 0) ? -((-prod + 255) / 256) : prod / 256;  // floor
            sum = sum + prod;
        end
        return sum[15:0];
    endfunction

    task automatic write_reg(input logic [2:0] v, input logic sel, input logic [15:0] data);
        reg_write = 1'b1;
        reg_voice = v;
        reg_sel   = sel;
        reg_data  = data;
        @(posedge reg_clk);
        #drive_delay;
        reg_write = 1'b0;
        if (sel == synth_pkg::reg_sel_pitch) begin
            ref_inc[v] = data;
        end else begin
            ref_attack[v]  = data[15:8];
            ref_release[v] = data[7:0];
        end
    endtask

    task automatic send_note(input logic [2:0] v, input logic on);
        bit taken;
        note_valid = 1'b1;
        note_voice = v;
        note_on    = on;
        taken = 0;
        while (!taken) begin
            @(posedge reg_clk);
            taken = note_ready;
        end
        #drive_delay;
        note_valid = 1'b0;
        ref_key[v] = on;
    endtask

    task automatic check_voice_free();
        logic [nv-1:0] want;
        for (int v = 0; v < nv; v++) begin
            want[v] = (ref_level[v] == 0);
        end
        if (voice_free !== want) begin
            $display("** Error at %0t: voice_free expected %b, seen %b", $time, want, voice_free);
            tb_errors++;
        end
    endtask

    task automatic run_frame();
        logic [31:0] r;
        bit          taken, trig_done;
        i_checker.expect_sample(expected_frame_sample());
        trig = 1'b1;
        @(posedge reg_clk);
        #drive_delay;
        trig = 1'b0;
        taken = 0;
        trig_done = !trig_in_hold;
        while (!taken) begin
            @(posedge reg_clk);
            taken = sample_valid && sample_ready;
            #drive_delay;
            r = next_random();
            if (!taken && sample_valid && !trig_done) begin
                trig = 1'b1;  // engine is in hold, must not start a frame
                sample_ready = 1'b0;
                trig_done = 1;
            end else begin
                trig = 1'b0;
                sample_ready = stall_mode ? (r[31] | r[30]) : 1'b1;
            end
        end
        check_voice_free();
    endtask

    task automatic random_setup();
        logic [31:0] r, d;
        r = next_random();
        repeat (r[31:30]) begin
            r = next_random();
            d = next_random();
            write_reg(r[31:29], r[28], d[31:16]);
        end
        r = next_random();
        repeat (r[31:30]) begin
            r = next_random();
            send_note(r[31:29], r[28]);
        end
    endtask

    initial begin
        reg_clk = 1'b0;
        forever #(clk_period / 2) reg_clk = ~reg_clk;
    end

    always @(posedge reg_clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the run stalled and did not finish within %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        trig = 1'b0;
        note_valid = 1'b0;
        note_voice = '0;
        note_on = 1'b0;
        reg_write = 1'b0;
        reg_voice = '0;
        reg_sel = 1'b0;
        reg_data = '0;
        sample_ready = 1'b1;
        for (int v = 0; v < nv; v++) begin
            ref_phase[v] = '0;
            ref_inc[v] = '0;
            ref_attack[v] = '0;
            ref_release[v] = '0;
            ref_level[v] = '0;
            ref_key[v] = 1'b0;
        end
        repeat (reset_cycles) @(posedge reg_clk);
        #drive_delay;
        reset = 1'b0;
        if (voice_free !== {nv{1'b1}} || note_ready !== 1'b1) begin
            $display("** Error at %0t: after reset voice_free %b, note_ready %b",
                     $time, voice_free, note_ready);
            tb_errors++;
        end
        repeat (3) run_frame();  // silent engine
        write_reg(3'd2, synth_pkg::reg_sel_pitch, 16'h0c00);
        write_reg(3'd2, synth_pkg::reg_sel_env, {8'd40, 8'd0});
        send_note(3'd2, 1'b1);
        repeat (12) run_frame();  // attack up to saturation
        write_reg(3'd2, synth_pkg::reg_sel_env, {8'd40, 8'd40});
        send_note(3'd2, 1'b0);
        repeat (8) run_frame();  // release down to zero
        if (voice_free[2] !== 1'b1) begin
            $display("** Error at %0t: voice 2 not free after release", $time);
            tb_errors++;
        end
        repeat (12) begin
            random_setup();
            run_frame();
        end
        stall_mode = 1;
        repeat (25) begin
            random_setup();
            trig_in_hold = next_random() >> 31;
            run_frame();
        end
        repeat (20) @(posedge reg_clk);  // no stray sample after the last frame
        $display("error count: %0d sample checks, %0d other checks, %0d samples never seen",
                 i_checker.error_count, tb_errors, i_checker.pending);
        if (i_checker.error_count + tb_errors + i_checker.pending == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* synth_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module synth_checker (
    input wire                                      reg_clk,
    input wire                                      reset,
    input wire                                      trig,
    input wire                                      note_ready,
    input wire                                      sample_valid,
    input wire                                      sample_ready,
    input wire signed [synth_pkg::sample_width-1:0] sample
);

    localparam int latency = 11;  // trig edge to sample_valid rise

    logic signed [synth_pkg::sample_width-1:0] expected_q [$];
    logic signed [synth_pkg::sample_width-1:0] held;
    logic signed [synth_pkg::sample_width-1:0] want;
    int   error_count = 0;
    int   pending = 0;
    int   cycle = 0;
    int   trig_cycle = 0;
    logic frame_open = 1'b0;  // trig taken, sample not yet accepted
    logic valid_seen = 1'b0;

    task automatic expect_sample(input logic signed [synth_pkg::sample_width-1:0] value);
        expected_q.push_back(value);
        pending++;
    endtask

    always @(posedge reg_clk) begin
        if (reset) begin
            frame_open = 1'b0;
            valid_seen = 1'b0;
        end else begin
            if (frame_open && note_ready) begin
                $display("** Error at %0t: note_ready high during a frame", $time);
                error_count++;
            end
            if (trig && !frame_open) begin  // trig in hold is ignored by the engine
                frame_open = 1'b1;
                trig_cycle = cycle;
            end
            if (sample_valid) begin
                if (!valid_seen) begin
                    valid_seen = 1'b1;
                    held = sample;
                    // seen one edge after it was raised
                    if (!frame_open || cycle - 1 - trig_cycle != latency) begin
                        $display("** Error at %0t: sample_valid rose %0d cycles after trig, expected %0d",
                                 $time, cycle - 1 - trig_cycle, latency);
                        error_count++;
                    end
                end else if (sample !== held) begin
                    $display("** Error at %0t: held sample changed from %0d to %0d",
                             $time, held, sample);
                    error_count++;
                end
                if (sample_ready) begin
                    if (expected_q.size() == 0) begin
                        $display("a sample of %0d was accepted at %0t with no sample expected",
                                 sample, $time);
                        error_count++;
                    end else begin
                        want = expected_q.pop_front();
                        pending--;
                        if (sample !== want) begin
                            $display("** Error at %0t: sample expected %0d, seen %0d",
                                     $time, want, sample);
                            error_count++;
                        end
                    end
                    frame_open = 1'b0;
                    valid_seen = 1'b0;
                end
            end else if (valid_seen) begin
                $display("sample_valid dropped at %0t before the sample was accepted", $time);
                error_count++;
                valid_seen = 1'b0;
            end
        end
        cycle++;
    end

endmodule

`default_nettype wire

/* synth_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module synth_engine (
    input wire                                       reg_clk,
    input wire                                       reset,
    input wire                                       trig,
    input wire                                       note_valid,
    input wire [synth_pkg::voice_width-1:0]          note_voice,
    input wire                                       note_on,
    input wire                                       reg_write,
    input wire [synth_pkg::voice_width-1:0]          reg_voice,
    input wire                                       reg_sel,
    input wire [synth_pkg::phase_width-1:0]          reg_data,
    input wire                                       sample_ready,
    output logic                                     note_ready,
    output logic                                     sample_valid,
    output logic signed [synth_pkg::sample_width-1:0] sample,
    output logic [synth_pkg::num_voices-1:0]         voice_free
);

    logic                                     slot_start;
    logic [synth_pkg::voice_width-1:0]        slot;
    logic                                     slot_last;
    logic                                     slot_en;
    logic                                     busy;
    logic                                     mix_clear;
    logic                                     mix_en;
    logic                                     mix_taken;
    logic [synth_pkg::num_voices-1:0]         keys_on;
    logic signed [synth_pkg::wave_width-1:0]  wave;
    logic [synth_pkg::level_width-1:0]        level;

    slot_counter i_slot_counter (
        .reg_clk      ( reg_clk ),
        .reset        ( reset ),
        .slot_start   ( slot_start ),
        .slot         ( slot ),          // output
        .slot_last    ( slot_last )      // output
    );

    frame_sequencer i_frame_sequencer (
        .reg_clk      ( reg_clk ),
        .reset        ( reset ),
        .trig         ( trig ),
        .slot_last    ( slot_last ),
        .sample_ready ( sample_ready ),
        .mix_taken    ( mix_taken ),
        .slot_start   ( slot_start ),    // output
        .slot_en      ( slot_en ),       // output
        .busy         ( busy ),          // output
        .mix_clear    ( mix_clear ),     // output
        .mix_en       ( mix_en ),        // output
        .sample_valid ( sample_valid )   // output
    );

    note_sync i_note_sync (
        .reg_clk      ( reg_clk ),
        .reset        ( reset ),
        .note_valid   ( note_valid ),
        .note_voice   ( note_voice ),
        .note_on      ( note_on ),
        .busy         ( busy ),
        .note_ready   ( note_ready ),    // output
        .keys_on      ( keys_on )        // output
    );

    phase_accum i_phase_accum (
        .reg_clk      ( reg_clk ),
        .reset        ( reset ),
        .slot         ( slot ),
        .slot_en      ( slot_en ),
        .reg_write    ( reg_write ),
        .reg_voice    ( reg_voice ),
        .reg_sel      ( reg_sel ),
        .reg_data     ( reg_data ),
        .wave         ( wave )           // output
    );

    env_gen i_env_gen (
        .reg_clk      ( reg_clk ),
        .reset        ( reset ),
        .slot         ( slot ),
        .slot_en      ( slot_en ),
        .keys_on      ( keys_on ),
        .reg_write    ( reg_write ),
        .reg_voice    ( reg_voice ),
        .reg_sel      ( reg_sel ),
        .reg_data     ( reg_data ),
        .level        ( level ),         // output
        .voice_free   ( voice_free )     // output
    );

    voice_mixer i_voice_mixer (
        .reg_clk      ( reg_clk ),
        .reset        ( reset ),
        .wave         ( wave ),
        .level        ( level ),
        .mix_clear    ( mix_clear ),
        .mix_en       ( mix_en ),
        .sample_ready ( sample_ready ),
        .sample_valid ( sample_valid ),
        .sample       ( sample ),        // output
        .mix_taken    ( mix_taken )      // output
    );

endmodule

`default_nettype wire

/* voice_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module voice_mixer (
    input wire                                       reg_clk,
    input wire                                       reset,
    input wire signed [synth_pkg::wave_width-1:0]    wave,
    input wire [synth_pkg::level_width-1:0]          level,
    input wire                                       mix_clear,
    input wire                                       mix_en,
    input wire                                       sample_ready,
    input wire                                       sample_valid,
    output logic signed [synth_pkg::sample_width-1:0] sample,
    output logic                                     mix_taken
);

    logic signed [synth_pkg::prod_width-1:0]   full;
    logic signed [synth_pkg::prod_width-1:0]   scaled;
    logic signed [synth_pkg::sample_width-1:0] prod;
    logic                                      prod_valid;
    logic signed [synth_pkg::sample_width-1:0] acc;

    // level treated as unsigned, so a zero msb is added
    assign full   = wave * $signed({1'b0, level});
    assign scaled = full >>> synth_pkg::level_width;  // floor division by 256

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= mix_en;
        end
    end

    always_ff @(posedge reg_clk) begin
        prod <= scaled[synth_pkg::sample_width-1:0];  // fits, at most 9 bits of magnitude
    end

    always_ff @(posedge reg_clk) begin
        if (mix_clear) begin
            acc <= '0;
        end else if (prod_valid) begin
            acc <= acc + prod;
        end
    end

    assign sample    = acc;  // steady in hold, nothing accumulates there
    assign mix_taken = sample_valid && sample_ready;

endmodule

`default_nettype wire

/* env_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module env_gen (
    input wire                                 reg_clk,
    input wire                                 reset,
    input wire [synth_pkg::voice_width-1:0]    slot,
    input wire                                 slot_en,
    input wire [synth_pkg::num_voices-1:0]     keys_on,
    input wire                                 reg_write,
    input wire [synth_pkg::voice_width-1:0]    reg_voice,
    input wire                                 reg_sel,
    input wire [synth_pkg::phase_width-1:0]    reg_data,
    output logic [synth_pkg::level_width-1:0]  level,
    output logic [synth_pkg::num_voices-1:0]   voice_free
);

    logic [synth_pkg::level_width-1:0] attack_rate  [synth_pkg::num_voices];
    logic [synth_pkg::level_width-1:0] release_rate [synth_pkg::num_voices];
    logic [synth_pkg::level_width-1:0] lvl          [synth_pkg::num_voices];
    logic [synth_pkg::level_width:0]   rise;   // extra bit catches overflow
    logic [synth_pkg::level_width:0]   fall;   // extra bit catches underflow
    logic [synth_pkg::level_width-1:0] next_lvl;
    synth_pkg::reg_word_t              word;
    logic                              rate_write;

    assign word       = reg_data;
    assign rate_write = reg_write && (reg_sel == synth_pkg::reg_sel_env);

    assign rise = {1'b0, lvl[slot]} + {1'b0, attack_rate[slot]};
    assign fall = {1'b0, lvl[slot]} - {1'b0, release_rate[slot]};

    always_comb begin
        if (keys_on[slot]) begin
            next_lvl = rise[synth_pkg::level_width] ? '1 : rise[synth_pkg::level_width-1:0];
        end else begin
            next_lvl = fall[synth_pkg::level_width] ? '0 : fall[synth_pkg::level_width-1:0];
        end
    end

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            for (int v = 0; v < synth_pkg::num_voices; v++) begin
                attack_rate[v]  <= '0;
                release_rate[v] <= '0;
                lvl[v]          <= '0;
            end
        end else begin
            if (rate_write) begin
                attack_rate[reg_voice]  <= word.env.attack_rate;
                release_rate[reg_voice] <= word.env.release_rate;
            end
            if (slot_en) begin
                lvl[slot] <= next_lvl;  // one step per frame
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (slot_en) begin
            level <= next_lvl;  // aligned with wave
        end
    end

    always_comb begin
        for (int v = 0; v < synth_pkg::num_voices; v++) begin
            voice_free[v] = (lvl[v] == '0);
        end
    end

endmodule

`default_nettype wire

/* phase_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_accum (
    input wire                                     reg_clk,
    input wire                                     reset,
    input wire [synth_pkg::voice_width-1:0]        slot,
    input wire                                     slot_en,
    input wire                                     reg_write,
    input wire [synth_pkg::voice_width-1:0]        reg_voice,
    input wire                                     reg_sel,
    input wire [synth_pkg::phase_width-1:0]        reg_data,
    output logic signed [synth_pkg::wave_width-1:0] wave
);

    logic [synth_pkg::phase_width-1:0] inc   [synth_pkg::num_voices];
    logic [synth_pkg::phase_width-1:0] phase [synth_pkg::num_voices];
    logic [synth_pkg::phase_width-1:0] next_phase;
    synth_pkg::reg_word_t              word;
    logic                              inc_write;

    assign word       = reg_data;
    assign inc_write  = reg_write && (reg_sel == synth_pkg::reg_sel_pitch);
    assign next_phase = phase[slot] + inc[slot];  // wraps modulo 2**16

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            for (int v = 0; v < synth_pkg::num_voices; v++) begin
                inc[v]   <= '0;
                phase[v] <= '0;
            end
        end else begin
            if (inc_write) begin
                inc[reg_voice] <= word.inc;
            end
            if (slot_en) begin
                phase[slot] <= next_phase;
            end
        end
    end

    // top byte with msb flipped gives a zero-centered sawtooth
    always_ff @(posedge reg_clk) begin
        if (slot_en) begin
            wave <= {~next_phase[synth_pkg::phase_width-1],
                     next_phase[synth_pkg::phase_width-2 -: synth_pkg::wave_width-1]};
        end
    end

endmodule

`default_nettype wire

/* note_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module note_sync (
    input wire                                 reg_clk,
    input wire                                 reset,
    input wire                                 note_valid,
    input wire [synth_pkg::voice_width-1:0]    note_voice,
    input wire                                 note_on,
    input wire                                 busy,
    output logic                               note_ready,
    output logic [synth_pkg::num_voices-1:0]   keys_on
);

    logic note_take;

    assign note_ready = ~busy;  // events only between frames
    assign note_take  = note_valid && note_ready;

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            keys_on <= '0;
        end else if (note_take) begin
            keys_on[note_voice] <= note_on;  // 1 key on, 0 key off
        end
    end

endmodule

`default_nettype wire

/* frame_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
    input wire      reg_clk,
    input wire      reset,
    input wire      trig,
    input wire      slot_last,
    input wire      sample_ready,
    input wire      mix_taken,
    output logic    slot_start,
    output logic    slot_en,
    output logic    busy,
    output logic    mix_clear,
    output logic    mix_en,
    output logic    sample_valid
);

    synth_pkg::seq_state_t state;
    logic                  drain_cnt;  // counts the drain cycles
    logic                  trig_take;

    assign trig_take  = (state == synth_pkg::idle) && trig;  // trig outside idle is dropped
    assign slot_start = trig_take;
    assign mix_clear  = trig_take;
    assign slot_en    = (state == synth_pkg::scan);
    assign busy       = (state != synth_pkg::idle) || trig;  // notes wait for the next frame

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            state        <= synth_pkg::idle;
            drain_cnt    <= 1'b0;
            mix_en       <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            mix_en <= slot_en;  // wave and level arrive one cycle after the visit
            case (state)
                synth_pkg::idle: begin
                    if (trig_take) begin
                        state <= synth_pkg::scan;
                    end
                end
                synth_pkg::scan: begin
                    if (slot_last) begin
                        state     <= synth_pkg::drain;
                        drain_cnt <= 1'b0;
                    end
                end
                synth_pkg::drain: begin
                    if (drain_cnt == 1'(synth_pkg::drain_cycles - 1)) begin
                        state <= synth_pkg::hold;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                synth_pkg::hold: begin
                    if (mix_taken) begin
                        state        <= synth_pkg::idle;
                        sample_valid <= 1'b0;
                    end else begin
                        sample_valid <= 1'b1;  // rises one cycle after entering hold
                    end
                end
                default: state <= synth_pkg::idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* slot_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_counter (
    input wire                                 reg_clk,
    input wire                                 reset,
    input wire                                 slot_start,
    output logic [synth_pkg::voice_width-1:0]  slot,
    output logic                               slot_last
);

    logic running;  // high while a scan is in progress

    assign slot_last = running &&
                       (slot == synth_pkg::voice_width'(synth_pkg::num_voices - 1));

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            slot    <= '0;
            running <= 1'b0;
        end else if (slot_start) begin
            slot    <= '0;  // first voice on the next cycle
            running <= 1'b1;
        end else if (running) begin
            if (slot_last) begin
                running <= 1'b0;  // park on the last voice
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* synth_pkg.sv */
`default_nettype none

package synth_pkg;

    localparam int num_voices   = 8;
    localparam int voice_width  = $clog2(num_voices);  // = 3
    localparam int phase_width  = 16;
    localparam int level_width  = 8;                   // levels saturate at 0 and 255
    localparam int wave_width   = 8;                   // signed sawtooth sample
    localparam int sample_width = 16;                  // signed mixed output
    localparam int prod_width   = wave_width + level_width + 1;

    // pipeline depth between the last visit and the final accumulate
    localparam int drain_cycles = 2;

    localparam logic reg_sel_pitch = 1'b0;
    localparam logic reg_sel_env   = 1'b1;

    typedef enum logic [1:0] {
        idle,   // waiting for trig
        scan,   // visiting slots 0 to num_voices-1
        drain,  // flushing wave and product registers
        hold    // sample offered until taken
    } seq_state_t;

    // one register word with two readings
    typedef union packed {
        logic [phase_width-1:0] inc;      // reg_sel_pitch
        struct packed {
            logic [level_width-1:0] attack_rate;   // upper byte
            logic [level_width-1:0] release_rate;  // lower byte
        } env;                            // reg_sel_env
    } reg_word_t;

endpackage

`default_nettype wire
